/* rpPkg.sv */
////////////////////////////////////////////////////////////
// Shared constants and types for the RP drive register model
// Register numbers, function codes and field positions
////////////////////////////////////////////////////////////

package rpPkg;

   // Bus and register widths
   localparam int dataWidth = 36;
   localparam int regWidth  = 16;
   localparam int addrWidth = 5;

   typedef logic [addrWidth-1:0] rpAddrT;
   typedef logic [regWidth-1:0]  rpRegT;

   // Drive register numbers
   localparam rpAddrT regCS1 = 5'd0;
   localparam rpAddrT regDS  = 5'd1;
   localparam rpAddrT regDA  = 5'd5;
   localparam rpAddrT regOF  = 5'd9;
   localparam rpAddrT regDC  = 5'd10;

   // CS1 function field, GO in bit 0
   localparam int funcWidth = 5;
   localparam int funcHi    = 5;
   localparam int funcLo    = 1;
   localparam int goBit     = 0;

   localparam logic [funcWidth-1:0] funcSeek   = 5'd2;
   localparam logic [funcWidth-1:0] funcDrvClr = 5'd4;
   localparam logic [funcWidth-1:0] funcCenter = 5'd7;
   localparam logic [funcWidth-1:0] funcPreset = 5'd8;
   localparam logic [funcWidth-1:0] funcWrite  = 5'd24;
   localparam logic [funcWidth-1:0] funcWriteH = 5'd25;

   // Offset register fields
   localparam int ofFmt22Pos = 12;
   localparam int ofEciPos   = 11;
   localparam int ofHciPos   = 10;
   localparam int ofOfdPos   = 7;
   localparam int ofOfsHi    = 6;
   localparam int ofOfsLo    = 0;
   localparam int ofsWidth   = ofOfsHi - ofOfsLo + 1;

   // Desired address (track, sector) and desired cylinder fields
   localparam int daTrkHi  = 12;
   localparam int daTrkLo  = 8;
   localparam int daSecHi  = 5;
   localparam int daSecLo  = 0;
   localparam int dcCylHi  = 9;
   localparam int dcCylLo  = 0;
   localparam int trkWidth = daTrkHi - daTrkLo + 1;
   localparam int secWidth = daSecHi - daSecLo + 1;
   localparam int cylWidth = dcCylHi - dcCylLo + 1;

   // Status register drive-ready bit
   localparam int dsDRY = 7;

endpackage

/* rpHostPort.sv */
////////////////////////////////////////////////////////////
// Host side of the drive, four-phase req/ack front stage
// Captures one access per req and raises ack after done
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module rpHostPort (
   input  logic                         clk,
   input  logic                         rpPRESET,
   input  logic                         req,
   input  logic                         wr,
   input  rpPkg::rpAddrT                addr,
   input  logic [rpPkg::dataWidth-1:0]  wrData,
   input  logic                         done,
   output logic                         ack,
   output logic                         accStb,
   output logic                         accWr,
   output rpPkg::rpAddrT                accAddr,
   output logic [rpPkg::dataWidth-1:0]  accData
);

   import rpPkg::*;

   typedef enum logic [1:0] {
      stIdle,
      stBusy,
      stAcked
   } hostStateT;

   hostStateT state;

   ////////////////////////////////////////////////////////////
   // Handshake FSM
   ////////////////////////////////////////////////////////////

   always_ff @(posedge clk)
   begin
      if (rpPRESET)
      begin
         state  <= stIdle;
         accStb <= 1'b0;
      end
      else
      begin
         // Strobe lasts one cycle only
         accStb <= 1'b0;
         case (state)
            stIdle:
               if (req)
               begin
                  accStb <= 1'b1;
                  state  <= stBusy;
               end
            // Wait for read stage to finish
            stBusy:
               if (done)
                  state <= stAcked;
            // Hold ack until host lets go of req
            stAcked:
               if (!req)
                  state <= stIdle;
            default:
               state <= stIdle;
         endcase
      end
   end

   // Access capture, only on a fresh request
   always_ff @(posedge clk)
   begin
      if (state == stIdle && req)
      begin
         accWr   <= wr;
         accAddr <= addr;
         accData <= wrData;
      end
   end

   assign ack = (state == stAcked);

endmodule

/* rpCmdDecode.sv */
////////////////////////////////////////////////////////////
// Second stage, register and function decode
// Emits one-cycle load and command pulses, runs seek timer
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module rpCmdDecode #(
   parameter int seekCycles = 20
) (
   input  logic                         clk,
   input  logic                         rpPRESET,
   input  logic                         accStb,
   input  logic                         accWr,
   input  rpPkg::rpAddrT                accAddr,
   input  logic [rpPkg::dataWidth-1:0]  accData,
   output logic                         wrOF,
   output logic                         wrDA,
   output logic                         wrDC,
   output logic [rpPkg::dataWidth-1:0]  loadData,
   output logic                         initCmd,
   output logic                         presetCmd,
   output logic                         centerCmd,
   output logic                         seekCmd,
   output logic                         writeCmd,
   output logic                         writeHCmd,
   output logic                         rdStb,
   output rpPkg::rpAddrT                rdAddr,
   output logic                         ready
);

   import rpPkg::*;

   localparam int cntWidth = $clog2(seekCycles + 1);

   logic                 wrAcc;
   logic                 goCmd;
   logic [funcWidth-1:0] funcCode;
   logic                 startSeek;
   logic [cntWidth-1:0]  seekCount;

   // Writes only count while drive is ready
   assign wrAcc     = accStb & accWr & ready;
   assign funcCode  = accData[funcHi:funcLo];
   assign goCmd     = wrAcc & (accAddr == regCS1) & accData[goBit];
   assign startSeek = goCmd & ((funcCode == funcSeek) | (funcCode == funcCenter));

   ////////////////////////////////////////////////////////////
   // Decoded pulses
   ////////////////////////////////////////////////////////////

   always_ff @(posedge clk)
   begin
      if (rpPRESET)
      begin
         wrOF      <= 1'b0;
         wrDA      <= 1'b0;
         wrDC      <= 1'b0;
         initCmd   <= 1'b0;
         presetCmd <= 1'b0;
         centerCmd <= 1'b0;
         seekCmd   <= 1'b0;
         writeCmd  <= 1'b0;
         writeHCmd <= 1'b0;
         rdStb     <= 1'b0;
      end
      else
      begin
         wrOF      <= wrAcc & (accAddr == regOF);
         wrDA      <= wrAcc & (accAddr == regDA);
         wrDC      <= wrAcc & (accAddr == regDC);
         // Drive clear doubles as init
         initCmd   <= goCmd & (funcCode == funcDrvClr);
         presetCmd <= goCmd & (funcCode == funcPreset);
         centerCmd <= goCmd & (funcCode == funcCenter);
         seekCmd   <= goCmd & (funcCode == funcSeek);
         writeCmd  <= goCmd & (funcCode == funcWrite);
         writeHCmd <= goCmd & (funcCode == funcWriteH);
         // Every access gets a read-stage turn
         rdStb     <= accStb;
      end
   end

   // Payload for the register stage
   always_ff @(posedge clk)
   begin
      if (accStb)
      begin
         loadData <= accData;
         // Writes point at CS1, which reads as zero
         rdAddr   <= accWr ? regCS1 : accAddr;
      end
   end

   ////////////////////////////////////////////////////////////
   // Seek timer
   ////////////////////////////////////////////////////////////

   always_ff @(posedge clk)
   begin
      if (rpPRESET)
         seekCount <= '0;
      else if (startSeek)
         seekCount <= cntWidth'(seekCycles);
      else if (seekCount != '0)
         seekCount <= seekCount - 1'b1;
   end

   // Drive is busy while the timer runs
   assign ready = (seekCount == '0);

endmodule

/* rpOffsetReg.sv */
////////////////////////////////////////////////////////////
// Offset register (OF) with per-field clear conditions
// Loaded from the decode stage, clears win over loads
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module rpOffsetReg (
   input  logic                         clk,
   input  logic                         rpPRESET,
   input  logic                         wrOF,
   input  logic [rpPkg::dataWidth-1:0]  loadData,
   input  logic                         initCmd,
   input  logic                         presetCmd,
   input  logic                         centerCmd,
   input  logic                         seekCmd,
   input  logic                         writeCmd,
   input  logic                         writeHCmd,
   output rpPkg::rpRegT                 rpOF
);

   import rpPkg::*;

   logic                ofFmt22;
   logic                ofEci;
   logic                ofHci;
   logic                ofOfd;
   logic [ofsWidth-1:0] ofOfs;
   logic                headClr;

   // Any head motion or write drops the offset
   assign headClr = initCmd | centerCmd | seekCmd | writeCmd | writeHCmd;

   ////////////////////////////////////////////////////////////
   // Format and correction-inhibit bits
   ////////////////////////////////////////////////////////////

   always_ff @(posedge clk)
   begin
      if (rpPRESET | presetCmd)
      begin
         ofFmt22 <= 1'b0;
         ofEci   <= 1'b0;
         ofHci   <= 1'b0;
      end
      else if (wrOF)
      begin
         ofFmt22 <= loadData[ofFmt22Pos];
         ofEci   <= loadData[ofEciPos];
         ofHci   <= loadData[ofHciPos];
      end
   end

   // Offset direction and magnitude
   always_ff @(posedge clk)
   begin
      if (rpPRESET | headClr)
      begin
         ofOfd <= 1'b0;
         ofOfs <= '0;
      end
      else if (wrOF)
      begin
         ofOfd <= loadData[ofOfdPos];
         ofOfs <= loadData[ofOfsHi:ofOfsLo];
      end
   end

   // Assemble word, spare bits zero
   always_comb
   begin
      rpOF                  = '0;
      rpOF[ofFmt22Pos]      = ofFmt22;
      rpOF[ofEciPos]        = ofEci;
      rpOF[ofHciPos]        = ofHci;
      rpOF[ofOfdPos]        = ofOfd;
      rpOF[ofOfsHi:ofOfsLo] = ofOfs;
   end

endmodule

/* rpAddrRegs.sv */
////////////////////////////////////////////////////////////
// Desired address (DA) and desired cylinder (DC) registers
// Masked to track, sector and cylinder; preset clears both
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module rpAddrRegs (
   input  logic                         clk,
   input  logic                         rpPRESET,
   input  logic                         wrDA,
   input  logic                         wrDC,
   input  logic [rpPkg::dataWidth-1:0]  loadData,
   input  logic                         presetCmd,
   output rpPkg::rpRegT                 rpDA,
   output rpPkg::rpRegT                 rpDC
);

   import rpPkg::*;

   logic [trkWidth-1:0] daTrk;
   logic [secWidth-1:0] daSec;
   logic [cylWidth-1:0] dcCyl;

   ////////////////////////////////////////////////////////////
   // Track and sector
   ////////////////////////////////////////////////////////////

   always_ff @(posedge clk)
   begin
      if (rpPRESET | presetCmd)
      begin
         daTrk <= '0;
         daSec <= '0;
      end
      else if (wrDA)
      begin
         daTrk <= loadData[daTrkHi:daTrkLo];
         daSec <= loadData[daSecHi:daSecLo];
      end
   end

   // Cylinder
   always_ff @(posedge clk)
   begin
      if (rpPRESET | presetCmd)
         dcCyl <= '0;
      else if (wrDC)
         dcCyl <= loadData[dcCylHi:dcCylLo];
   end

   // Unused bits read back as zero
   always_comb
   begin
      rpDA                  = '0;
      rpDA[daTrkHi:daTrkLo] = daTrk;
      rpDA[daSecHi:daSecLo] = daSec;
      rpDC                  = '0;
      rpDC[dcCylHi:dcCylLo] = dcCyl;
   end

endmodule

/* rpReadMux.sv */
////////////////////////////////////////////////////////////
// Third stage, read select and latch
// Holds the read word for the host and flags completion
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module rpReadMux (
   input  logic          clk,
   input  logic          rpPRESET,
   input  logic          rdStb,
   input  rpPkg::rpAddrT rdAddr,
   input  rpPkg::rpRegT  rpOF,
   input  rpPkg::rpRegT  rpDA,
   input  rpPkg::rpRegT  rpDC,
   input  logic          ready,
   output rpPkg::rpRegT  rdData,
   output logic          done
);

   import rpPkg::*;

   rpRegT statWord;
   rpRegT selWord;

   // Status word, only DRY modelled
   always_comb
   begin
      statWord        = '0;
      statWord[dsDRY] = ready;
   end

   // Register select, CS1 and unknown numbers give zero
   always_comb
   begin
      case (rdAddr)
         regDS:   selWord = statWord;
         regDA:   selWord = rpDA;
         regOF:   selWord = rpOF;
         regDC:   selWord = rpDC;
         default: selWord = '0;
      endcase
   end

   always_ff @(posedge clk)
   begin
      if (rdStb)
         rdData <= selWord;
   end

   always_ff @(posedge clk)
   begin
      if (rpPRESET)
         done <= 1'b0;
      else
         done <= rdStb;
   end

endmodule

/* rpDrive.sv */
////////////////////////////////////////////////////////////
// Drive register block top level
// Host port, decode and register stages wired in a pipeline
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module rpDrive #(
   parameter int seekCycles = 20
) (
   input  logic                         clk,
   input  logic                         rpPRESET,
   input  logic                         req,
   input  logic                         wr,
   input  rpPkg::rpAddrT                addr,
   input  logic [rpPkg::dataWidth-1:0]  wrData,
   output logic                         ack,
   output rpPkg::rpRegT                 rdData
);

   import rpPkg::*;

   // Host port to decoder
   logic                 accStb;
   logic                 accWr;
   rpAddrT               accAddr;
   logic [dataWidth-1:0] accData;

   // Decoder to register stage
   logic                 wrOF;
   logic                 wrDA;
   logic                 wrDC;
   logic [dataWidth-1:0] loadData;
   logic                 initCmd;
   logic                 presetCmd;
   logic                 centerCmd;
   logic                 seekCmd;
   logic                 writeCmd;
   logic                 writeHCmd;
   logic                 rdStb;
   rpAddrT               rdAddr;
   logic                 ready;

   // Register contents and completion
   rpRegT                rpOF;
   rpRegT                rpDA;
   rpRegT                rpDC;
   logic                 done;

   rpHostPort hostPort_i (
      .clk(clk), .rpPRESET(rpPRESET), .req(req), .wr(wr), .addr(addr),
      .wrData(wrData), .done(done), .ack(ack), .accStb(accStb),
      .accWr(accWr), .accAddr(accAddr), .accData(accData)
   );

   rpCmdDecode #(.seekCycles(seekCycles)) cmdDecode_i (
      .clk(clk), .rpPRESET(rpPRESET), .accStb(accStb), .accWr(accWr),
      .accAddr(accAddr), .accData(accData), .wrOF(wrOF), .wrDA(wrDA),
      .wrDC(wrDC), .loadData(loadData), .initCmd(initCmd),
      .presetCmd(presetCmd), .centerCmd(centerCmd), .seekCmd(seekCmd),
      .writeCmd(writeCmd), .writeHCmd(writeHCmd), .rdStb(rdStb),
      .rdAddr(rdAddr), .ready(ready)
   );

   rpOffsetReg offsetReg_i (
      .clk(clk), .rpPRESET(rpPRESET), .wrOF(wrOF), .loadData(loadData),
      .initCmd(initCmd), .presetCmd(presetCmd), .centerCmd(centerCmd),
      .seekCmd(seekCmd), .writeCmd(writeCmd), .writeHCmd(writeHCmd),
      .rpOF(rpOF)
   );

   rpAddrRegs addrRegs_i (
      .clk(clk), .rpPRESET(rpPRESET), .wrDA(wrDA), .wrDC(wrDC),
      .loadData(loadData), .presetCmd(presetCmd), .rpDA(rpDA), .rpDC(rpDC)
   );

   rpReadMux readMux_i (
      .clk(clk), .rpPRESET(rpPRESET), .rdStb(rdStb), .rdAddr(rdAddr),
      .rpOF(rpOF), .rpDA(rpDA), .rpDC(rpDC), .ready(ready),
      .rdData(rdData), .done(done)
   );

endmodule

/* rpDrive_assert.sv */
////////////////////////////////////////////////////////////
// Bound checks on the host handshake and the decode stage
// Attached to every rpDrive instance by the bind below
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module rpDriveAssert (
   input logic clk,
   input logic rpPRESET,
   input logic req,
   input logic ack,
   input logic wrOF,
   input logic wrDA,
   input logic wrDC,
   input logic ready,
   input logic initCmd,
   input logic presetCmd,
   input logic centerCmd,
   input logic seekCmd,
   input logic writeCmd,
   input logic writeHCmd
);

   logic anyCmd;

   assign anyCmd = initCmd | presetCmd | centerCmd | seekCmd | writeCmd | writeHCmd;

   // ack only answers a pending request
   ackRiseReq: assert property (@(posedge clk) disable iff (rpPRESET)
      $rose(ack) |-> $past(req))
      else $error("ack rose without a pending req");

   // Host must let go first
   ackFallReq: assert property (@(posedge clk) disable iff (rpPRESET)
      $fell(ack) |-> !$past(req))
      else $error("ack fell while req was still high");

   // One register load per access
   wrOneHot: assert property (@(posedge clk) disable iff (rpPRESET)
      $onehot0({wrOF, wrDA, wrDC}))
      else $error("more than one register load strobe in a cycle");

   // Decode samples ready one edge before the pulse
   cmdReady: assert property (@(posedge clk) disable iff (rpPRESET)
      anyCmd |-> $past(ready))
      else $error("drive command decoded while the drive was not ready");

endmodule

bind rpDrive rpDriveAssert driveAssert_i (
   .clk(clk), .rpPRESET(rpPRESET), .req(req), .ack(ack),
   .wrOF(wrOF), .wrDA(wrDA), .wrDC(wrDC), .ready(ready),
   .initCmd(initCmd), .presetCmd(presetCmd), .centerCmd(centerCmd),
   .seekCmd(seekCmd), .writeCmd(writeCmd), .writeHCmd(writeHCmd)
);

/* tb_rpDrive.sv */
////////////////////////////////////////////////////////////
// Testbench for the drive register block
// Table of host accesses, random OF writes, then a seek run
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module tb_rpDrive;

   import rpPkg::*;

   // Long enough to cover three blocked writes and a status read
   localparam int seekCycles  = 30;
   localparam int resetCycles = 16;
   localparam int tableLen    = 31;
   localparam int randCount   = 8;

   // Readable field masks of OF, DA, DC and the DRY bit
   localparam rpRegT ofMask = 16'h1CFF;
   localparam rpRegT daMask = 16'h1F3F;
   localparam rpRegT dcMask = 16'h03FF;
   localparam rpRegT dryVal = 16'h0080;

   typedef struct {
      logic                 wr;
      rpAddrT               addr;
      logic [dataWidth-1:0] data;
      rpRegT                expVal;
   } stimT;

   logic                 clk;
   logic                 rpPRESET;
   logic                 req;
   logic                 wr;
   rpAddrT               addr;
   logic [dataWidth-1:0] wrData;
   logic                 ack;
   rpRegT                rdData;

   stimT   stimTable [tableLen];
   int     errorCount;
   int     checkCount;
   integer seed;

   rpDrive #(.seekCycles(seekCycles)) rpDrive_i (
      .clk(clk), .rpPRESET(rpPRESET), .req(req), .wr(wr), .addr(addr),
      .wrData(wrData), .ack(ack), .rdData(rdData)
   );

   initial
   begin
      clk = 1'b0;
      forever #2 clk = ~clk;
   end

   ////////////////////////////////////////////////////////////
   // Helpers
   ////////////////////////////////////////////////////////////

   // CS1 word with function field and GO
   function automatic logic [dataWidth-1:0] cmdWord(input logic [funcWidth-1:0] func);
      logic [dataWidth-1:0] w;
      w                = '0;
      w[funcHi:funcLo] = func;
      w[goBit]         = 1'b1;
      return w;
   endfunction

   task automatic setEntry(input int idx, input logic w, input rpAddrT a,
                           input logic [dataWidth-1:0] d, input rpRegT e);
      stimTable[idx].wr     = w;
      stimTable[idx].addr   = a;
      stimTable[idx].data   = d;
      stimTable[idx].expVal = e;
   endtask

   // One four-phase access, data taken while ack is high
   task automatic hostAccess(input logic w, input rpAddrT a,
                             input logic [dataWidth-1:0] d, output rpRegT data);
      @(negedge clk);
      while (ack)
         @(negedge clk);
      req    = 1'b1;
      wr     = w;
      addr   = a;
      wrData = d;
      @(negedge clk);
      while (!ack)
         @(negedge clk);
      data = rdData;
      req  = 1'b0;
   endtask

   task automatic checkReg(input rpRegT got, input rpRegT exp, input string what);
      checkCount++;
      if (got !== exp)
      begin
         errorCount++;
         $display("FAILED at %0t ns: %s read 0x%04h, expected 0x%04h", $time, what, got, exp);
      end
   endtask

   task automatic checkReady(input logic got, input logic exp, input string what);
      checkCount++;
      if (got !== exp)
      begin
         errorCount++;
         $display("FAILED at %0t ns: %s DRY is %b, expected %b", $time, what, got, exp);
      end
   endtask

   // Status polling, bounded
   task automatic pollReady(input string what);
      rpRegT st;
      int    polls;
      logic  seen;
      polls = 0;
      seen  = 1'b0;
      while (!seen && polls < 2 * seekCycles)
      begin
         hostAccess(1'b0, regDS, '0, st);
         seen = st[dsDRY];
         polls++;
      end
      if (!seen)
      begin
         errorCount++;
         $display("The drive did not become ready again after the %s command", what);
      end
   endtask

   ////////////////////////////////////////////////////////////
   // Watchdog
   ////////////////////////////////////////////////////////////

   initial
   begin
      repeat ((tableLen + randCount) * 40 + 4 * seekCycles) @(posedge clk);
      $display("The simulation timed out before all accesses completed");
      $display("Some tests failed");
      $finish;
   end

   ////////////////////////////////////////////////////////////
   // Main sequence
   ////////////////////////////////////////////////////////////

   initial
   begin
      rpRegT                got;
      logic [31:0]          rndHi;
      logic [31:0]          rndLo;
      logic [dataWidth-1:0] rndData;

      rpPRESET   = 1'b1;
      req        = 1'b0;
      wr         = 1'b0;
      addr       = '0;
      wrData     = '0;
      errorCount = 0;
      checkCount = 0;
      seed       = 32'h604d;

      // Reset values, then full OF mask
      setEntry(0, 1'b0, regOF, '0, 16'h0000);
      setEntry(1, 1'b0, regDA, '0, 16'h0000);
      setEntry(2, 1'b0, regDC, '0, 16'h0000);
      setEntry(3, 1'b0, regDS, '0, dryVal);
      setEntry(4, 1'b1, regOF, 36'hF_FFFF_FFFF, 16'h0000);
      setEntry(5, 1'b0, regOF, '0, ofMask);
      // DA and DC masking, then preset
      setEntry(6, 1'b1, regDA, 36'h0_0000_ABCD, 16'h0000);
      setEntry(7, 1'b0, regDA, '0, 16'hABCD & daMask);
      setEntry(8, 1'b1, regDC, 36'h9_0000_F3A7, 16'h0000);
      setEntry(9, 1'b0, regDC, '0, 16'hF3A7 & dcMask);
      setEntry(10, 1'b1, regOF, 36'h0_0000_1C95, 16'h0000);
      setEntry(11, 1'b0, regOF, '0, 16'h1C95);
      setEntry(12, 1'b1, regCS1, cmdWord(funcPreset), 16'h0000);
      setEntry(13, 1'b0, regDA, '0, 16'h0000);
      setEntry(14, 1'b0, regDC, '0, 16'h0000);
      setEntry(15, 1'b0, regOF, '0, 16'h0095);
      // Drive clear, write and write-header drop only OFD and OFS
      setEntry(16, 1'b1, regOF, 36'h0_0000_1CFF, 16'h0000);
      setEntry(17, 1'b1, regCS1, cmdWord(funcDrvClr), 16'h0000);
      setEntry(18, 1'b0, regOF, '0, 16'h1C00);
      setEntry(19, 1'b1, regOF, 36'h0_0000_1CC3, 16'h0000);
      setEntry(20, 1'b0, regOF, '0, 16'h1CC3);
      setEntry(21, 1'b1, regCS1, cmdWord(funcWrite), 16'h0000);
      setEntry(22, 1'b0, regOF, '0, 16'h1C00);
      setEntry(23, 1'b1, regOF, 36'h0_0000_1C22, 16'h0000);
      setEntry(24, 1'b1, regCS1, cmdWord(funcWriteH), 16'h0000);
      setEntry(25, 1'b0, regOF, '0, 16'h1C00);
      // CS1 and unlisted numbers read zero, seek without GO does nothing
      setEntry(26, 1'b0, regCS1, '0, 16'h0000);
      setEntry(27, 1'b0, 5'd3, '0, 16'h0000);
      setEntry(28, 1'b0, 5'd31, '0, 16'h0000);
      setEntry(29, 1'b1, regCS1, 36'h0_0000_0004, 16'h0000);
      setEntry(30, 1'b0, regDS, '0, dryVal);

      repeat (resetCycles) @(posedge clk);
      @(negedge clk);
      rpPRESET = 1'b0;

      for (int i = 0; i < tableLen; i++)
      begin
         hostAccess(stimTable[i].wr, stimTable[i].addr, stimTable[i].data, got);
         checkReg(got, stimTable[i].expVal, $sformatf("table entry %0d", i));
      end

      // Random OF data, only the five fields stick
      for (int i = 0; i < randCount; i++)
      begin
         rndHi   = $random(seed);
         rndLo   = $random(seed);
         rndData = {rndHi[3:0], rndLo};
         hostAccess(1'b1, regOF, rndData, got);
         hostAccess(1'b0, regOF, '0, got);
         checkReg(got, rndData[regWidth-1:0] & ofMask, $sformatf("random OF %0d", i));
      end

      // Seek, writes while busy are dropped
      hostAccess(1'b1, regOF, 36'h0_0000_1CFF, got);
      hostAccess(1'b1, regDA, 36'h0_0000_0A15, got);
      hostAccess(1'b1, regDC, 36'h0_0000_0123, got);
      hostAccess(1'b1, regCS1, cmdWord(funcSeek), got);
      hostAccess(1'b1, regOF, 36'h0_0000_0055, got);
      hostAccess(1'b1, regDA, 36'h0_0000_1F3F, got);
      hostAccess(1'b1, regDC, 36'h0_0000_03FF, got);
      hostAccess(1'b0, regDS, '0, got);
      checkReady(got[dsDRY], 1'b0, "status during seek");
      hostAccess(1'b0, regOF, '0, got);
      checkReg(got, 16'h1C00, "OF after seek");
      hostAccess(1'b0, regDA, '0, got);
      checkReg(got, 16'h0A15, "DA while not ready");
      hostAccess(1'b0, regDC, '0, got);
      checkReg(got, 16'h0123, "DC while not ready");
      pollReady("seek");
      hostAccess(1'b0, regDS, '0, got);
      checkReady(got[dsDRY], 1'b1, "status after seek");

      // Ready again, OF loads, then center clears the offset
      hostAccess(1'b1, regOF, 36'h0_0000_0C9A, got);
      hostAccess(1'b0, regOF, '0, got);
      checkReg(got, 16'h0C9A, "OF after seek done");
      hostAccess(1'b1, regCS1, cmdWord(funcCenter), got);
      hostAccess(1'b0, regOF, '0, got);
      checkReg(got, 16'h0C00, "OF after center");
      hostAccess(1'b0, regDS, '0, got);
      checkReady(got[dsDRY], 1'b0, "status during center");
      pollReady("center");

      $display("Checks run: %0d, errors: %0d", checkCount, errorCount);
      if (errorCount == 0)
         $display("All tests passed");
      else
         $display("Some tests failed");
      $finish;
   end

endmodule

/* sources.f */
rpPkg.sv
rpHostPort.sv
rpCmdDecode.sv
rpOffsetReg.sv
rpAddrRegs.sv
rpReadMux.sv
rpDrive.sv
rpDrive_assert.sv
tb_rpDrive.sv

/* Makefile */
# Verilator simulation of the RP drive register model

VERILATOR = verilator
VFLAGS    = --binary --timing --assert -Wno-fatal
TOP       = tb_rpDrive
FILELIST  = sources.f
OBJDIR    = obj_dir
LOG       = sim.log
PASSMSG   = All tests passed

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)
	./$(OBJDIR)/V$(TOP) | tee $(LOG)
	grep -q "$(PASSMSG)" $(LOG)

clean:
	rm -rf $(OBJDIR) $(LOG)
